//--- logic/dcache_pkg.sv
//************************************************
// Data cache shared definitions
// Geometry, bus widths and controller states
//************************************************

package dcache_pkg;

   // Address and data widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int BYTES_W = 4;

   // Cache geometry, 4-word lines in 16 sets of 2 ways
   localparam int LINE_LOG2 = 4;
   localparam int WORD_SEL_W = 2;
   localparam int SETS_LOG2 = 4;
   localparam int WAYS = 2;
   localparam int WAY_W = 1;
   localparam int TAG_W = 8;
   localparam int BLK_AW = 6;

   // Miss controller states
   localparam int ST_W = 3;
   localparam logic [ST_W-1:0] ST_IDLE = 3'd0;
   localparam logic [ST_W-1:0] ST_WB = 3'd1;
   localparam logic [ST_W-1:0] ST_WAIT_B = 3'd2;
   localparam logic [ST_W-1:0] ST_FILL = 3'd3;
   localparam logic [ST_W-1:0] ST_READOUT = 3'd4;

endpackage

//--- logic/dcache_tag_store.sv
//************************************************
// Data cache tag store
// Per-way valid, dirty, tag and LRU arrays with
// registered read, write bypass and boot clear
//************************************************

`timescale 1ns/1ps

module dcache_tag_store
   import dcache_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            rd_en,
   input  logic [SETS_LOG2-1:0]            rd_idx,
   input  logic [SETS_LOG2-1:0]            wr_idx,
   input  logic [WAYS-1:0]                 tag_we,
   input  logic [WAYS-1:0]                 valid_in,
   input  logic [WAYS-1:0]                 dirty_in,
   input  logic [WAYS-1:0][TAG_W-1:0]      tag_in,
   input  logic [WAYS-1:0]                 lru_we,
   input  logic [WAYS-1:0][WAY_W-1:0]      lru_in,
   output logic [WAYS-1:0]                 valid_out,
   output logic [WAYS-1:0]                 dirty_out,
   output logic [WAYS-1:0][TAG_W-1:0]      tag_out,
   output logic [WAYS-1:0][WAY_W-1:0]      lru_out,
   output logic                            booting
);

   logic [SETS_LOG2-1:0] boot_cnt;
   logic [SETS_LOG2-1:0] w_idx;

   // Boot sweep walks the sets from the top down
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         boot_cnt <= '1;
         booting <= 1'b1;
      end
      else if (booting)
      begin
         boot_cnt <= boot_cnt - 1'b1;
         if (boot_cnt == '0)
            booting <= 1'b0;
      end
   end

   assign w_idx = booting ? boot_cnt : wr_idx;

   for (genvar w = 0; w < WAYS; w++)
   begin : g_way
      logic [TAG_W+1:0] tag_mem [1<<SETS_LOG2];
      logic [WAY_W-1:0] lru_mem [1<<SETS_LOG2];
      logic             tag_wen;
      logic             lru_wen;
      logic [TAG_W+1:0] tag_wdata;
      logic [WAY_W-1:0] lru_wdata;

      // Boot writes invalid, clean, rank equal to way number
      assign tag_wen = booting | tag_we[w];
      assign lru_wen = booting | lru_we[w];
      assign tag_wdata = booting ? '0 : {valid_in[w], dirty_in[w], tag_in[w]};
      assign lru_wdata = booting ? WAY_W'(w) : lru_in[w];

      always_ff @(posedge clk)
      begin
         if (tag_wen)
            tag_mem[w_idx] <= tag_wdata;
         if (lru_wen)
            lru_mem[w_idx] <= lru_wdata;
      end

      // Registered read, same-cycle write to the read set wins
      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
         begin
            {valid_out[w], dirty_out[w], tag_out[w]} <= '0;
            lru_out[w] <= '0;
         end
         else if (rd_en)
         begin
            if (tag_wen && (w_idx == rd_idx))
               {valid_out[w], dirty_out[w], tag_out[w]} <= tag_wdata;
            else
               {valid_out[w], dirty_out[w], tag_out[w]} <= tag_mem[rd_idx];
            if (lru_wen && (w_idx == rd_idx))
               lru_out[w] <= lru_wdata;
            else
               lru_out[w] <= lru_mem[rd_idx];
         end
      end
   end

endmodule

//--- logic/dcache_tag_update.sv
//************************************************
// Data cache tag update
// Hit and victim detection, next tag and LRU words
//************************************************

`timescale 1ns/1ps

module dcache_tag_update
   import dcache_pkg::*;
(
   input  logic [WAYS-1:0]                 valid_in,
   input  logic [WAYS-1:0]                 dirty_in,
   input  logic [WAYS-1:0][TAG_W-1:0]      tag_in,
   input  logic [WAYS-1:0][WAY_W-1:0]      lru_in,
   input  logic [TAG_W-1:0]                req_tag,
   input  logic                            access,
   input  logic                            is_write,
   output logic                            hit,
   output logic [WAYS-1:0]                 match,
   output logic [WAY_W-1:0]                hit_way,
   output logic [WAY_W-1:0]                victim_way,
   output logic                            victim_dirty,
   output logic [TAG_W-1:0]                victim_tag,
   output logic [WAYS-1:0]                 tag_we,
   output logic [WAYS-1:0]                 valid_out,
   output logic [WAYS-1:0]                 dirty_out,
   output logic [WAYS-1:0][TAG_W-1:0]      tag_out,
   output logic [WAYS-1:0]                 lru_we,
   output logic [WAYS-1:0][WAY_W-1:0]      lru_out
);

   logic [WAY_W-1:0] hit_rank;

   // Way lookup, the victim holds LRU rank 0
   always_comb
   begin
      hit_way = '0;
      victim_way = '0;
      for (int w = 0; w < WAYS; w++)
      begin
         match[w] = valid_in[w] && (tag_in[w] == req_tag);
         if (match[w])
            hit_way = WAY_W'(w);
         if (lru_in[w] == '0)
            victim_way = WAY_W'(w);
      end
   end

   assign hit = |match;
   assign hit_rank = lru_in[hit_way];
   assign victim_dirty = valid_in[victim_way] & dirty_in[victim_way];
   assign victim_tag = tag_in[victim_way];

   always_comb
   begin
      for (int w = 0; w < WAYS; w++)
      begin
         tag_we[w] = 1'b0;
         valid_out[w] = valid_in[w];
         dirty_out[w] = dirty_in[w];
         tag_out[w] = tag_in[w];
         lru_we[w] = 1'b0;
         lru_out[w] = lru_in[w];
         if (access && hit)
         begin
            // Matched way goes to the top, ranks above it drop by one
            lru_we[w] = 1'b1;
            if (match[w])
            begin
               lru_out[w] = '1;
               if (is_write)
               begin
                  tag_we[w] = 1'b1;
                  dirty_out[w] = 1'b1;
               end
            end
            else if (lru_in[w] > hit_rank)
               lru_out[w] = lru_in[w] - 1'b1;
         end
         else if (access && (victim_way == WAY_W'(w)))
         begin
            // Miss installs the new line, clean
            tag_we[w] = 1'b1;
            valid_out[w] = 1'b1;
            dirty_out[w] = 1'b0;
            tag_out[w] = req_tag;
         end
      end
   end

endmodule

//--- logic/dcache_data_ram.sv
//************************************************
// Data cache line storage for one way
// Dual port, byte-masked writes on port A
//************************************************

`timescale 1ns/1ps

module dcache_data_ram
   import dcache_pkg::*;
(
   input  logic                  clk,
   input  logic                  a_en,
   input  logic [BLK_AW-1:0]     a_addr,
   input  logic [BYTES_W-1:0]    a_we,
   input  logic [DATA_W-1:0]     a_din,
   output logic [DATA_W-1:0]     a_dout,
   input  logic                  b_en,
   input  logic [BLK_AW-1:0]     b_addr,
   output logic [DATA_W-1:0]     b_dout
);

   logic [DATA_W-1:0] mem [1<<BLK_AW];

   // Port A writes, refill and write-back reads
   always_ff @(posedge clk)
   begin
      if (a_en)
      begin
         for (int b = 0; b < BYTES_W; b++)
            if (a_we[b])
               mem[a_addr][b*8 +: 8] <= a_din[b*8 +: 8];
         a_dout <= mem[a_addr];
      end
   end

   // CPU read port
   always_ff @(posedge clk)
   begin
      if (b_en)
         b_dout <= mem[b_addr];
   end

endmodule

//--- logic/dcache_refill_ctrl.sv
//************************************************
// Data cache miss controller
// Write-back and refill bursts on the data bus
//************************************************

`timescale 1ns/1ps

module dcache_refill_ctrl
   import dcache_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     booting,
   input  logic                     req_valid,
   input  logic                     hit,
   input  logic                     victim_dirty,
   input  logic [TAG_W-1:0]         victim_tag,
   input  logic [TAG_W-1:0]         req_tag,
   input  logic [SETS_LOG2-1:0]     req_idx,
   input  logic                     arw_ready,
   input  logic                     w_ready,
   input  logic                     b_valid,
   input  logic                     r_valid,
   output logic [ST_W-1:0]          state,
   output logic [WORD_SEL_W-1:0]    beat_cnt,
   output logic                     arw_valid,
   output logic [ADDR_W-1:0]        arw_addr,
   output logic                     awe,
   output logic                     w_valid,
   output logic                     b_ready
);

   logic [ST_W-1:0] state_nxt;
   logic            wb_beat;
   logic            fill_beat;
   logic            last_beat;
   logic            burst_start;

   assign wb_beat = (state == ST_WB) & w_ready;
   assign fill_beat = (state == ST_FILL) & r_valid;
   assign last_beat = &beat_cnt;

   always_comb
   begin
      state_nxt = state;
      case (state)
         ST_IDLE:
            if (req_valid && !hit && !booting)
               state_nxt = victim_dirty ? ST_WB : ST_FILL;
         ST_WB:
            if (wb_beat && last_beat)
               state_nxt = ST_WAIT_B;
         ST_WAIT_B:
            if (b_valid)
               state_nxt = ST_FILL;
         ST_FILL:
            if (fill_beat && last_beat)
               state_nxt = ST_READOUT;
         // Tags are read again here before the request retires
         ST_READOUT:
            state_nxt = ST_IDLE;
         default:
            state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= ST_IDLE;
      else
         state <= state_nxt;
   end

   // Word within the line, wraps at the end of each burst
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         beat_cnt <= '0;
      else if (wb_beat || fill_beat)
         beat_cnt <= beat_cnt + 1'b1;
   end

   assign burst_start = ((state_nxt == ST_WB) && (state != ST_WB)) ||
                        ((state_nxt == ST_FILL) && (state != ST_FILL));

   // Address valid from burst start until the slave takes it
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         arw_valid <= 1'b0;
      else if (burst_start)
         arw_valid <= 1'b1;
      else if (arw_ready)
         arw_valid <= 1'b0;
   end

   // Victim line for write-back, request line for fill
   always_ff @(posedge clk)
   begin
      if (burst_start)
         arw_addr <= {(state_nxt == ST_WB) ? victim_tag : req_tag, req_idx,
                      {LINE_LOG2{1'b0}}};
   end

   // RAM read takes a cycle, so write data trails the beat
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         w_valid <= 1'b0;
      else
         w_valid <= wb_beat;
   end

   assign awe = (state == ST_WB);
   assign b_ready = (state == ST_WAIT_B);

endmodule

//--- logic/dcache_top.sv
//************************************************
// Two-way write-back data cache, two-stage pipe
// CPU port in front, burst data bus behind
//************************************************

`timescale 1ns/1ps

module dcache_top
   import dcache_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  req,
   input  logic [ADDR_W-1:0]     addr,
   input  logic [BYTES_W-1:0]    wmsk,
   input  logic [DATA_W-1:0]     wdat,
   output logic                  stall,
   output logic [DATA_W-1:0]     rdat,
   output logic                  arw_valid,
   output logic [ADDR_W-1:0]     arw_addr,
   output logic                  awe,
   input  logic                  arw_ready,
   input  logic                  w_ready,
   output logic                  w_valid,
   output logic [DATA_W-1:0]     w_data,
   input  logic                  b_valid,
   output logic                  b_ready,
   input  logic                  r_valid,
   input  logic [DATA_W-1:0]     r_data
);

   logic                            s1_valid;
   logic [ADDR_W-1:0]               s1_addr;
   logic [BYTES_W-1:0]              s1_wmsk;
   logic [DATA_W-1:0]               s1_wdat;
   logic [SETS_LOG2-1:0]            s1_idx;
   logic [TAG_W-1:0]                s1_tag;
   logic [WORD_SEL_W-1:0]           s1_word;
   logic [ADDR_W-1:0]               rd_addr;
   logic                            rd_en;
   logic [ST_W-1:0]                 state;
   logic [WORD_SEL_W-1:0]           beat_cnt;
   logic                            booting;
   logic                            access;
   logic                            hit;
   logic                            hit_wr;
   logic [WAYS-1:0]                 match;
   logic [WAY_W-1:0]                hit_way;
   logic [WAY_W-1:0]                victim_way;
   logic                            victim_dirty;
   logic [TAG_W-1:0]                victim_tag;
   logic [WAYS-1:0]                 st_valid, st_dirty, up_valid, up_dirty;
   logic [WAYS-1:0][TAG_W-1:0]      st_tag, up_tag;
   logic [WAYS-1:0][WAY_W-1:0]      st_lru, up_lru;
   logic [WAYS-1:0]                 tag_we, lru_we;
   logic [BLK_AW-1:0]               a_addr;
   logic [BYTES_W-1:0]              a_we;
   logic [DATA_W-1:0]               a_din;
   logic                            a_sel;
   logic [WAYS-1:0][DATA_W-1:0]     a_dout, b_dout;
   logic                            fwd_hit;
   logic                            fwd_r;
   logic [DATA_W-1:0]               fwd_data;
   logic [BYTES_W-1:0]              fwd_msk;
   logic [DATA_W-1:0]               rd_word;

   // Stage-1 request registers
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         s1_valid <= 1'b0;
      else if (!stall)
         s1_valid <= req;
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         s1_addr <= addr;
         s1_wmsk <= wmsk;
         s1_wdat <= wdat;
      end
   end

   assign s1_idx = s1_addr[LINE_LOG2 +: SETS_LOG2];
   assign s1_tag = s1_addr[ADDR_W-1 -: TAG_W];
   assign s1_word = s1_addr[LINE_LOG2-1 -: WORD_SEL_W];

   // Hold the stage-1 address while stalled, re-read it in READOUT
   assign rd_addr = stall ? s1_addr : addr;
   assign rd_en = ~stall | (state == ST_READOUT);

   assign access = s1_valid & (state == ST_IDLE);
   assign hit_wr = access & hit & (|s1_wmsk);
   assign stall = (state != ST_IDLE) | booting | (s1_valid & ~hit);

   dcache_tag_store tag_store_i (
      .clk(clk), .rst_n(rst_n), .rd_en(rd_en),
      .rd_idx(rd_addr[LINE_LOG2 +: SETS_LOG2]), .wr_idx(s1_idx),
      .tag_we(tag_we), .valid_in(up_valid), .dirty_in(up_dirty), .tag_in(up_tag),
      .lru_we(lru_we), .lru_in(up_lru),
      .valid_out(st_valid), .dirty_out(st_dirty), .tag_out(st_tag), .lru_out(st_lru),
      .booting(booting)
   );

   dcache_tag_update tag_update_i (
      .valid_in(st_valid), .dirty_in(st_dirty), .tag_in(st_tag), .lru_in(st_lru),
      .req_tag(s1_tag), .access(access), .is_write(|s1_wmsk),
      .hit(hit), .match(match), .hit_way(hit_way), .victim_way(victim_way),
      .victim_dirty(victim_dirty), .victim_tag(victim_tag),
      .tag_we(tag_we), .valid_out(up_valid), .dirty_out(up_dirty), .tag_out(up_tag),
      .lru_we(lru_we), .lru_out(up_lru)
   );

   dcache_refill_ctrl refill_ctrl_i (
      .clk(clk), .rst_n(rst_n), .booting(booting), .req_valid(s1_valid), .hit(hit),
      .victim_dirty(victim_dirty), .victim_tag(victim_tag), .req_tag(s1_tag),
      .req_idx(s1_idx), .arw_ready(arw_ready), .w_ready(w_ready), .b_valid(b_valid),
      .r_valid(r_valid), .state(state), .beat_cnt(beat_cnt), .arw_valid(arw_valid),
      .arw_addr(arw_addr), .awe(awe), .w_valid(w_valid), .b_ready(b_ready)
   );

   // Port A: burst beats on the victim way, CPU writes on a hit
   always_comb
   begin
      a_addr = {s1_idx, beat_cnt};
      a_we = '0;
      a_din = r_data;
      a_sel = 1'b0;
      case (state)
         ST_WB:
            a_sel = w_ready;
         ST_FILL:
         begin
            a_we = '1;
            a_sel = r_valid;
         end
         default:
         begin
            a_addr = {s1_idx, s1_word};
            a_we = s1_wmsk;
            a_din = s1_wdat;
         end
      endcase
   end

   for (genvar w = 0; w < WAYS; w++)
   begin : g_ram
      dcache_data_ram data_ram_i (
         .clk(clk),
         .a_en((a_sel & (victim_way == WAY_W'(w))) | (hit_wr & match[w])),
         .a_addr(a_addr), .a_we(a_we), .a_din(a_din), .a_dout(a_dout[w]),
         .b_en(rd_en),
         .b_addr(rd_addr[LINE_LOG2+SETS_LOG2-1 -: BLK_AW]),
         .b_dout(b_dout[w])
      );
   end

   assign w_data = a_dout[victim_way];

   // Read of the word being written this cycle sees old RAM data
   assign fwd_hit = hit_wr & rd_en &
      (rd_addr[ADDR_W-1:LINE_LOG2-WORD_SEL_W] == s1_addr[ADDR_W-1:LINE_LOG2-WORD_SEL_W]);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         fwd_r <= 1'b0;
      else if (rd_en)
         fwd_r <= fwd_hit;
   end

   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         fwd_data <= s1_wdat;
         fwd_msk <= s1_wmsk;
      end
   end

   assign rd_word = b_dout[hit_way];

   // Merge the stored bytes over the RAM word
   always_comb
   begin
      rdat = rd_word;
      if (fwd_r)
         for (int b = 0; b < BYTES_W; b++)
            if (fwd_msk[b])
               rdat[b*8 +: 8] = fwd_data[b*8 +: 8];
   end

endmodule

//--- verif/dcache_properties.sv
//**************************************************
// Data cache assertions
// Tag match, bus address and write beat rules
//**************************************************

`timescale 1ns/1ps

module dcache_properties
   import dcache_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  stall,
   input  logic                  booting,
   input  logic [WAYS-1:0]       match,
   input  logic                  arw_valid,
   input  logic                  arw_ready,
   input  logic [ADDR_W-1:0]     arw_addr,
   input  logic                  awe,
   input  logic                  w_valid
);

   // At most one way holds the requested tag
   match_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(match))
      else $error("More than one way matched the request tag");

   addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (arw_valid && !arw_ready) |=> $stable(arw_addr))
      else $error("Burst address changed while waiting for the slave");

   // Write data trails the write-back beat by one cycle
   wdata_in_wb: assert property (@(posedge clk) disable iff (!rst_n) w_valid |-> $past(awe))
      else $error("Write beat without a write-back cycle before it");

   // No CPU traffic and no bus activity while the tags are swept
   boot_stall: assert property (@(posedge clk) disable iff (!rst_n)
      booting |-> (stall && !arw_valid && !w_valid))
      else $error("CPU port open or bus busy during the boot sweep");

endmodule

//--- verif/tb_dcache.sv
//**************************************************
// Data cache testbench
// Golden-file CPU stimulus, bus memory model with
// random back-pressure, read data and timing checks
//**************************************************

`timescale 1ns/1ps

module tb_dcache
   import dcache_pkg::*;
();

   localparam int MAX_OPS = 32;
   localparam int OP_W = 88;
   localparam int BOOT_CYCLES = 16;
   // Worst-case write-back plus refill with 3-cycle gaps, rounded up
   localparam int CYCLES_PER_OP = 124;
   localparam int TIMEOUT_CYCLES = 2 * BOOT_CYCLES + MAX_OPS * CYCLES_PER_OP;
   localparam int MEM_WORDS = 1 << (ADDR_W - 2);
   localparam int PH_IDLE = 0;
   localparam int PH_ADDR = 1;
   localparam int PH_WDATA = 2;
   localparam int PH_BRESP = 3;
   localparam int PH_RDATA = 4;

   logic                  clk;
   logic                  rst_n;
   logic                  req;
   logic [ADDR_W-1:0]     addr;
   logic [BYTES_W-1:0]    wmsk;
   logic [DATA_W-1:0]     wdat;
   logic                  stall;
   logic [DATA_W-1:0]     rdat;
   logic                  arw_valid;
   logic [ADDR_W-1:0]     arw_addr;
   logic                  awe;
   logic                  arw_ready;
   logic                  w_ready;
   logic                  w_valid;
   logic [DATA_W-1:0]     w_data;
   logic                  b_valid;
   logic                  b_ready;
   logic                  r_valid;
   logic [DATA_W-1:0]     r_data;

   // Op word: flag, address, mask, write data, expected read data
   logic [OP_W-1:0]       golden [MAX_OPS];
   int                    n_ops;
   int                    checks;
   int                    data_errs;
   int                    timing_errs;
   int                    bus_errs;
   int                    wb_bursts;
   int                    cycle_cnt;
   logic [DATA_W-1:0]     mem [MEM_WORDS];
   logic                  wrote_line [1 << (ADDR_W - LINE_LOG2)];
   logic [31:0]           lfsr;
   int                    ph;
   int                    dly;
   logic [ADDR_W-1:0]     line_addr;
   int                    w_grant;
   int                    w_recv;
   int                    r_sent;

   dcache_top dut_i (
      .clk(clk), .rst_n(rst_n), .req(req), .addr(addr), .wmsk(wmsk), .wdat(wdat),
      .stall(stall), .rdat(rdat), .arw_valid(arw_valid), .arw_addr(arw_addr),
      .awe(awe), .arw_ready(arw_ready), .w_ready(w_ready), .w_valid(w_valid),
      .w_data(w_data), .b_valid(b_valid), .b_ready(b_ready), .r_valid(r_valid),
      .r_data(r_data)
   );

   bind dcache_top dcache_properties props_i (
      .clk(clk), .rst_n(rst_n), .stall(stall), .booting(booting), .match(match),
      .arw_valid(arw_valid), .arw_ready(arw_ready), .arw_addr(arw_addr),
      .awe(awe), .w_valid(w_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // Two LFSR bits give a delay of 0 to 3 cycles
   task automatic draw_delay(output int d);
      d = 0;
      for (int i = 0; i < 2; i++)
      begin
         d = (d << 1) | int'(lfsr[0]);
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic drive_op(input int idx);
      if (idx < n_ops)
      begin
         req = 1'b1;
         addr = golden[idx][83:68];
         wmsk = golden[idx][67:64];
         wdat = golden[idx][63:32];
      end
      else
      begin
         req = 1'b0;
         wmsk = '0;
      end
   endtask

   // Flag 1 needs the answer right after acceptance, flag 2 a stall first
   task automatic check_result(input logic [OP_W-1:0] op, input int waits);
      checks++;
      if ((op[67:64] == '0) && (rdat != op[31:0]))
      begin
         $display("FAILED at %0t: read of %h returned %h, expected %h",
                  $time, op[83:68], rdat, op[31:0]);
         data_errs++;
      end
      if ((op[87:84] == 4'h1) && (waits != 0))
      begin
         $display("FAILED at %0t: access to %h stalled %0d cycles, expected a hit",
                  $time, op[83:68], waits);
         timing_errs++;
      end
      if ((op[87:84] == 4'h2) && (waits == 0))
      begin
         $display("FAILED at %0t: access to %h did not stall, expected a miss",
                  $time, op[83:68]);
         timing_errs++;
      end
   endtask

   task automatic check_boot();
      int high_cycles;
      high_cycles = 0;
      @(negedge clk);
      while (stall && (high_cycles <= BOOT_CYCLES))
      begin
         high_cycles++;
         if (arw_valid || w_valid || b_ready)
         begin
            $display("Bus request raised during the boot sweep at %0t", $time);
            bus_errs++;
         end
         @(negedge clk);
      end
      if (high_cycles != BOOT_CYCLES)
      begin
         $display("FAILED at %0t: stall high for %0d cycles after reset, expected %0d",
                  $time, high_cycles, BOOT_CYCLES);
         timing_errs++;
      end
   endtask

   // One request outstanding for its answer, the next one already driven
   task automatic run_ops();
      logic [OP_W-1:0] cur;
      int              op_idx;
      int              wait_cnt;
      logic            pending;
      cur = '0;
      op_idx = 0;
      wait_cnt = 0;
      pending = 1'b0;
      @(posedge clk);
      #5;
      drive_op(op_idx);
      while ((op_idx < n_ops) || pending)
      begin
         @(negedge clk);
         if (pending && stall)
            wait_cnt++;
         else if (pending)
         begin
            check_result(cur, wait_cnt);
            pending = 1'b0;
         end
         if (req && !stall)
         begin
            cur = golden[op_idx];
            if (cur[67:64] != '0)
               wrote_line[cur[83:72]] = 1'b1;
            pending = 1'b1;
            wait_cnt = 0;
            op_idx++;
         end
         @(posedge clk);
         #5;
         drive_op(op_idx);
      end
   endtask

   // Bus slave, sees what the DUT samples at the coming edge
   task automatic observe_bus();
      if (w_valid)
      begin
         if (ph != PH_WDATA)
         begin
            $display("Write beat outside a write-back burst at %0t", $time);
            bus_errs++;
         end
         else
         begin
            mem[int'(line_addr[ADDR_W-1:2]) + w_recv] = w_data;
            w_recv++;
         end
      end
      case (ph)
         PH_IDLE:
            if (arw_valid)
            begin
               ph = PH_ADDR;
               draw_delay(dly);
            end
         PH_ADDR:
            if (arw_valid && arw_ready)
            begin
               line_addr = arw_addr;
               if (arw_addr[LINE_LOG2-1:0] != '0)
               begin
                  $display("Burst address %h is not line aligned", arw_addr);
                  bus_errs++;
               end
               if (awe && !wrote_line[arw_addr[ADDR_W-1:LINE_LOG2]])
               begin
                  $display("Write-back of line %h, which was never written", arw_addr);
                  bus_errs++;
               end
               ph = awe ? PH_WDATA : PH_RDATA;
               wb_bursts += int'(awe);
               w_grant = 0;
               w_recv = 0;
               r_sent = 0;
               draw_delay(dly);
            end
         PH_WDATA:
         begin
            if (w_ready && awe)
               w_grant++;
            if (w_recv == 4)
            begin
               ph = PH_BRESP;
               draw_delay(dly);
            end
         end
         PH_BRESP:
            if (b_valid && b_ready)
               ph = PH_IDLE;
         PH_RDATA:
            if (r_valid)
            begin
               r_sent++;
               if (r_sent == 4)
                  ph = PH_IDLE;
            end
         default:
            ph = PH_IDLE;
      endcase
   endtask

   task automatic drive_bus();
      arw_ready = 1'b0;
      w_ready = 1'b0;
      b_valid = 1'b0;
      r_valid = 1'b0;
      if (dly > 0 && ph != PH_IDLE)
         dly--;
      else if (ph == PH_ADDR)
         arw_ready = 1'b1;
      else if (ph == PH_BRESP)
         b_valid = 1'b1;
      else if ((ph == PH_WDATA) && (w_grant < 4))
      begin
         w_ready = 1'b1;
         draw_delay(dly);
      end
      else if (ph == PH_RDATA)
      begin
         r_valid = 1'b1;
         r_data = mem[int'(line_addr[ADDR_W-1:2]) + r_sent];
         draw_delay(dly);
      end
   endtask

   initial
   begin
      arw_ready = 1'b0;
      w_ready = 1'b0;
      b_valid = 1'b0;
      r_valid = 1'b0;
      r_data = '0;
      lfsr = 32'h31ac0921;
      ph = PH_IDLE;
      dly = 0;
      bus_errs = 0;
      wb_bursts = 0;
      // Each word holds its own byte address twice
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = {2{16'(i * 4)}};
      for (int i = 0; i < (1 << (ADDR_W - LINE_LOG2)); i++)
         wrote_line[i] = 1'b0;
      @(posedge rst_n);
      forever
      begin
         @(negedge clk);
         observe_bus();
         @(posedge clk);
         #5;
         drive_bus();
      end
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      rst_n = 1'b0;
      req = 1'b0;
      addr = '0;
      wmsk = '0;
      wdat = '0;
      checks = 0;
      data_errs = 0;
      timing_errs = 0;
      for (int i = 0; i < MAX_OPS; i++)
         golden[i] = '1;
      $readmemh("verif/dcache_golden.txt", golden);
      n_ops = 0;
      while ((n_ops < MAX_OPS) && (golden[n_ops] != '1))
         n_ops++;
      repeat (5) @(posedge clk);
      #5;
      rst_n = 1'b1;
      check_boot();
      run_ops();
      if (wb_bursts == 0)
      begin
         $display("No dirty line write-back was seen on the bus");
         bus_errs++;
      end
      $display("%0d ops, %0d checks, %0d data errors, %0d timing errors, %0d bus errors",
               n_ops, checks, data_errs, timing_errs, bus_errs);
      if ((data_errs + timing_errs + bus_errs) == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- verif/dcache_golden.txt
// flag_address_mask_wdata_expected; flag 1 needs a hit, flag 2 a miss
// mask 0 is a read checked against expected data, memory word at A starts as {A, A}
2_0120_0_00000000_01200120
1_0124_0_00000000_01240124
1_0128_0_00000000_01280128
1_012c_3_aabbccdd_00000000
1_012c_0_00000000_012cccdd
2_1034_0_00000000_10341034
2_2038_0_00000000_20382038
1_1030_0_00000000_10301030
2_303c_0_00000000_303c303c
1_1034_0_00000000_10341034
2_2038_0_00000000_20382038
2_4054_f_11223344_00000000
1_4054_0_00000000_11223344
1_4058_8_99000000_00000000
2_5050_0_00000000_50505050
2_6050_0_00000000_60506050
2_4054_0_00000000_11223344
1_4058_0_00000000_99584058
1_0124_0_00000000_01240124
1_012c_0_00000000_012cccdd

//--- sources.f
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_tag_update.sv
logic/dcache_data_ram.sv
logic/dcache_refill_ctrl.sv
logic/dcache_top.sv
verif/dcache_properties.sv
verif/tb_dcache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dcache -f sources.f -o tb_dcache_sim

./obj_dir/tb_dcache_sim 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "Simulation FAILED, see sim.log"
   exit 1
fi
echo "Simulation passed"
